/* vlog.f */
+incdir+common
common/exu_isa_pkg.sv
common/exu_pipe_pkg.sv
rtl/exu_regfile.sv
rtl/exu_decode.sv
disp/exu_disp.sv
disp/exu_oitf.sv
rtl/exu_alu.sv
rtl/exu_wbck.sv
rtl/exu.sv
sim/exu_checker.sv
sim/tb_exu.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing -Wall +incdir+common
LINT_FLAGS = --lint-only --timing -Wall +incdir+common
TOP        = tb_exu
FILELIST   = vlog.f

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

/* sim/tb_exu.sv */
// Testbench top: clock, reset, LFSR instruction source, LSU model, watchdog, DUT and checker
`timescale 1ns/10ps

module tb_exu import exu_isa_pkg::*; import exu_pipe_pkg::*; ();

  localparam logic [31:0] SEED      = 32'd96684;
  localparam int          N_INSTR   = 400;
  localparam int          PERIOD    = 100;
  localparam int          DRIVE_DLY = 10;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        valid;
  logic [31:0] ir;
  logic        ready;
  logic        agu_valid;
  logic        agu_ready;
  logic [31:0] agu_addr;
  itag_t       agu_itag;
  logic        lsu_valid;
  logic        lsu_ready;
  word_t       lsu_wdat;
  itag_t       lsu_itag;
  logic        wbck_ena;
  rfidx_t      wbck_rdidx;
  word_t       wbck_wdat;
  logic        oitf_empty;
  logic        exu_active;
  logic        done;
  int          mismatches;
  int          failures;

  logic [31:0] lfsr;
  itag_t       pend_itag [$]; // Loads held by the LSU model
  word_t       pend_addr [$];
  int          pend_due  [$];

  always #(PERIOD / 2) clk = ~clk;

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////
  // Random instruction, registers limited to x0..x7
  function automatic logic [31:0] make_instr();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [6:0]  opc;
    logic [31:0] word;
    int          sel;
    rd  = 5'(take_bits(3));
    rs1 = 5'(take_bits(3));
    rs2 = 5'(take_bits(3));
    imm = 12'(take_bits(12));
    f7  = F7_BASE;
    if (take_bits(4) == 32'd0) begin
      case (take_bits(2))
        32'd0:   opc = 7'b0110111; // LUI
        32'd1:   opc = 7'b0010111; // AUIPC
        32'd2:   opc = 7'b1100011; // Branch
        default: opc = 7'b0100011; // Store
      endcase
      word = {imm, rs1, 3'(take_bits(3)), rd, opc};
    end else begin
      case (take_bits(2))
        32'd2: begin
          sel = int'(take_bits(2));
          f3  = (sel == 0) ? F3_ADD_SUB : (sel == 1) ? F3_AND : (sel == 2) ? F3_OR : F3_XOR;
          word = {imm, rs1, f3, rd, OPC_OP_IMM};
        end
        32'd3:   word = {imm, rs1, F3_LW, rd, OPC_LOAD};
        default: begin
          sel = int'(take_bits(3)) % 6;
          case (sel)
            0: f3 = F3_ADD_SUB;
            1: begin
              f3 = F3_ADD_SUB;
              f7 = F7_SUB;
            end
            2: f3 = F3_AND;
            3: f3 = F3_OR;
            4: f3 = F3_XOR;
            default: f3 = F3_SLT;
          endcase
          word = {f7, rs2, rs1, f3, rd, OPC_OP};
        end
      endcase
    end
    return word;
  endfunction

  exu i_exu (
    .clk (clk), .i_rst_n (rst_n),
    .i_valid (valid), .o_ready (ready), .i_ir (ir),
    .o_agu_cmd_valid (agu_valid), .i_agu_cmd_ready (agu_ready),
    .o_agu_cmd_addr (agu_addr), .o_agu_cmd_itag (agu_itag),
    .i_lsu_valid (lsu_valid), .o_lsu_ready (lsu_ready),
    .i_lsu_wdat (lsu_wdat), .i_lsu_itag (lsu_itag),
    .o_wbck_ena (wbck_ena), .o_wbck_rdidx (wbck_rdidx), .o_wbck_wdat (wbck_wdat),
    .o_oitf_empty (oitf_empty), .o_exu_active (exu_active)
  );

  exu_checker u_checker (
    .clk (clk), .i_rst_n (rst_n), .i_done (done),
    .i_valid (valid), .i_ir (ir), .i_ready (ready),
    .i_agu_valid (agu_valid), .i_agu_ready (agu_ready),
    .i_agu_addr (agu_addr), .i_agu_itag (agu_itag),
    .i_lsu_valid (lsu_valid), .i_lsu_ready (lsu_ready),
    .i_wbck_ena (wbck_ena), .i_wbck_rdidx (wbck_rdidx), .i_wbck_wdat (wbck_wdat),
    .i_oitf_empty (oitf_empty), .i_active (exu_active),
    .o_mismatches (mismatches), .o_failures (failures)
  );

  ////////////////////////////////////////////////////////////
  // Stimulus, driven a fixed delay after each rising edge
  initial begin
    logic  instr_acc;
    logic  agu_acc;
    logic  lsu_acc;
    itag_t agu_itag_s;
    word_t agu_addr_s;
    int    issued;
    int    cyc;
    lfsr      = SEED;
    rst_n     = 1'b0;
    valid     = 1'b0;
    ir        = '0;
    agu_ready = 1'b0;
    lsu_valid = 1'b0;
    lsu_wdat  = '0;
    lsu_itag  = '0;
    done      = 1'b0;
    issued    = 0;
    cyc       = 0;
    repeat (2) @(posedge clk);
    #(DRIVE_DLY) rst_n = 1'b1;
    @(posedge clk);
    #(DRIVE_DLY);
    while ((issued < N_INSTR) || valid || (pend_itag.size() != 0)) begin
      @(negedge clk); // Handshakes settle by mid-cycle
      instr_acc  = valid & ready;
      agu_acc    = agu_valid & agu_ready;
      lsu_acc    = lsu_valid & lsu_ready;
      agu_itag_s = agu_itag;
      agu_addr_s = agu_addr;
      @(posedge clk);
      #(DRIVE_DLY);
      cyc++;
      if (lsu_acc) begin
        void'(pend_itag.pop_front());
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      if (agu_acc) begin
        pend_itag.push_back(agu_itag_s);
        pend_addr.push_back(agu_addr_s);
        pend_due.push_back(cyc + 1 + (int'(take_bits(3)) % 6)); // 1 to 6 cycles
      end
      if (instr_acc) valid = 1'b0;
      if (!valid && (issued < N_INSTR) && (take_bits(2) != 32'd0)) begin
        ir    = make_instr();
        valid = 1'b1;
        issued++;
      end
      agu_ready = (take_bits(2) != 32'd0);
      lsu_valid = (pend_itag.size() != 0) && (cyc >= pend_due[0]);
      lsu_itag  = (pend_itag.size() != 0) ? pend_itag[0] : '0;
      lsu_wdat  = (pend_addr.size() != 0) ? ~pend_addr[0] : '0; // Data is the inverted address
    end
    repeat (2) @(posedge clk);
    #(DRIVE_DLY) done = 1'b1;
    @(negedge clk);
    #1;
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if ((mismatches == 0) && (failures == 0)) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog, about 20 cycles per instruction
  initial begin
    #(N_INSTR * 20 * PERIOD);
    $display("Watchdog: the run timed out before all instructions retired");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* sim/exu_checker.sv */
// Reference model of the execution stage and comparison against the DUT ports
`timescale 1ns/10ps

module exu_checker import exu_isa_pkg::*; import exu_pipe_pkg::*; (
  input  logic        clk,
  input  logic        i_rst_n,
  input  logic        i_done,
  input  logic        i_valid,
  input  logic [31:0] i_ir,
  input  logic        i_ready,
  input  logic        i_agu_valid,
  input  logic        i_agu_ready,
  input  logic [31:0] i_agu_addr,
  input  itag_t       i_agu_itag,
  input  logic        i_lsu_valid,
  input  logic        i_lsu_ready,
  input  logic        i_wbck_ena,
  input  rfidx_t      i_wbck_rdidx,
  input  word_t       i_wbck_wdat,
  input  logic        i_oitf_empty,
  input  logic        i_active,
  output int          o_mismatches,
  output int          o_failures
);

  localparam int K_NONE = 0;
  localparam int K_ALU  = 1;
  localparam int K_LOAD = 2;

  word_t  model_rf [32];
  rfidx_t load_rd_q [$]; // Outstanding loads, oldest first
  word_t  load_addr_q [$];
  itag_t  next_itag;
  logic   settled = 1'b0;
  logic   final_done = 1'b0;
  int     mism_cnt = 0;
  int     fail_cnt = 0;

  assign o_mismatches = mism_cnt;
  assign o_failures   = fail_cnt;

  task automatic report_mismatch(input string msg);
    mism_cnt++;
    $display("mismatch at %0t ns: %s", $time, msg);
  endtask

  task automatic report_failure(input string msg);
    fail_cnt++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  // Supported RV32I subset
  function automatic int classify(input logic [31:0] ir);
    logic [2:0] f3;
    logic [6:0] f7;
    int         kind;
    f3   = ir[14:12];
    f7   = ir[31:25];
    kind = K_NONE;
    if (ir[6:0] == OPC_OP) begin
      if ((f3 inside {F3_ADD_SUB, F3_SLT, F3_XOR, F3_OR, F3_AND}) &&
          ((f7 == F7_BASE) || ((f7 == F7_SUB) && (f3 == F3_ADD_SUB)))) begin
        kind = K_ALU;
      end
    end else if (ir[6:0] == OPC_OP_IMM) begin
      if (f3 inside {F3_ADD_SUB, F3_XOR, F3_OR, F3_AND}) kind = K_ALU; // No SLTI
    end else if ((ir[6:0] == OPC_LOAD) && (f3 == F3_LW)) begin
      kind = K_LOAD;
    end
    return kind;
  endfunction

  function automatic word_t model_alu(input logic [31:0] ir, input word_t a, input word_t b);
    word_t r;
    case (ir[14:12])
      F3_ADD_SUB: r = (ir[5] && ir[30]) ? (a - b) : (a + b); // SUB in register form only
      F3_SLT:     r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_XOR:     r = a ^ b;
      F3_OR:      r = a | b;
      F3_AND:     r = a & b;
      default:    r = '0;
    endcase
    return r;
  endfunction

  // True when some outstanding load still has to write this register
  function automatic logic load_pending(input rfidx_t r);
    logic hit;
    hit = 1'b0;
    foreach (load_rd_q[i]) begin
      if (load_rd_q[i] == r) hit = 1'b1;
    end
    return hit;
  endfunction

  task automatic check_write(input rfidx_t rd, input word_t dat, input string what);
    if (rd == '0) begin
      if (i_wbck_ena) report_failure({what, " result written although rd is x0"});
    end else if (!i_wbck_ena) begin
      report_failure({what, " write-back did not happen"});
    end else if ((i_wbck_rdidx != rd) || (i_wbck_wdat != dat)) begin
      report_mismatch($sformatf("%s write x%0d=%h, expected x%0d=%h",
                                what, i_wbck_rdidx, i_wbck_wdat, rd, dat));
    end
    if (rd != '0) model_rf[rd] = dat;
  endtask

  ////////////////////////////////////////////////////////////
  // Sampled mid-cycle, describes what the next rising edge does
  always @(negedge clk) begin : check_cycle
    word_t  a;
    word_t  b;
    word_t  imm;
    rfidx_t rd;
    int     kind;
    logic   acc;
    if (!i_rst_n || !settled) begin
      if (i_agu_valid || i_wbck_ena || !i_oitf_empty || (i_active && !i_valid)) begin
        report_failure("outputs not idle during or just after reset");
      end
      if (!i_rst_n) begin
        for (int i = 0; i < 32; i++) model_rf[i] = '0;
        next_itag = '0;
      end
      settled = i_rst_n;
    end else begin
      kind = classify(i_ir);
      rd   = i_ir[11:7];
      imm  = {{20{i_ir[31]}}, i_ir[31:20]};
      a    = model_rf[i_ir[19:15]];
      b    = (i_ir[5] && (kind == K_ALU)) ? model_rf[i_ir[24:20]] : imm;
      acc  = i_valid && i_ready;
      if (!i_lsu_ready) report_failure("LSU write-back not ready while out of reset");
      if (i_oitf_empty != (load_rd_q.size() == 0)) begin
        report_mismatch($sformatf("OITF empty flag %b, expected %b", i_oitf_empty,
                                  load_rd_q.size() == 0));
      end
      if (i_active != ((load_rd_q.size() != 0) || i_valid)) begin
        report_mismatch($sformatf("active flag %b, expected %b", i_active,
                                  (load_rd_q.size() != 0) || i_valid));
      end
      if (i_wbck_ena && (i_wbck_rdidx == '0)) report_failure("register x0 written");
      if (i_lsu_valid && acc && (kind != K_LOAD)) begin
        report_failure("instruction accepted while the LSU owns the write port");
      end
      // Loads still in flight block readers and writers of their rd
      if (acc && (kind != K_NONE) &&
          (load_pending(i_ir[19:15]) ||
           ((kind == K_ALU) && i_ir[5] && load_pending(i_ir[24:20])) ||
           ((rd != '0) && load_pending(rd)))) begin
        report_failure("instruction accepted while it depends on an outstanding load");
      end
      if ((i_agu_valid && i_agu_ready) != (acc && (kind == K_LOAD))) begin
        report_failure("AGU handshake does not match the acceptance of a load");
      end
      if (i_agu_valid && !(i_valid && (kind == K_LOAD))) begin
        report_failure("AGU command valid without a load on the instruction input");
      end
      if (i_lsu_valid && i_lsu_ready) begin
        if (load_rd_q.size() == 0) begin
          report_failure("LSU write-back with no outstanding load");
        end else begin
          check_write(load_rd_q.pop_front(), ~load_addr_q.pop_front(), "load");
        end
      end else if (acc && (kind == K_ALU) && (rd != '0)) begin
        check_write(rd, model_alu(i_ir, a, b), "ALU");
      end else if (i_wbck_ena) begin
        report_failure("register write with no instruction to retire");
      end
      if (acc && (kind == K_LOAD)) begin
        if (i_agu_addr != (a + imm)) begin
          report_mismatch($sformatf("AGU address %h, expected %h", i_agu_addr, a + imm));
        end
        if (i_agu_itag != next_itag) begin
          report_mismatch($sformatf("AGU itag %0d, expected %0d", i_agu_itag, next_itag));
        end
        next_itag = next_itag + 1'b1;
        load_rd_q.push_back(rd);
        load_addr_q.push_back(a + imm);
      end
      // End of test, everything retired
      if (i_done && !final_done) begin
        final_done = 1'b1;
        if (!i_oitf_empty) report_failure("OITF not empty at the end of the test");
        if (load_rd_q.size() != 0) begin
          report_failure("expected load writes still queued at the end of the test");
        end
      end
    end
  end

endmodule

/* rtl/exu.sv */
// Execution stage top: regfile, decode, dispatch, OITF, ALU, write-back
`timescale 1ns/10ps
`include "exu_settings.svh"

module exu import exu_isa_pkg::*; import exu_pipe_pkg::*; (
  input  logic                       clk,
  input  logic                       i_rst_n,
  input  logic                       i_valid,       // Instruction handshake
  output logic                       o_ready,
  input  logic [`EXU_INSTR_SIZE-1:0] i_ir,
  output logic                       o_agu_cmd_valid, // AGU command to LSU
  input  logic                       i_agu_cmd_ready,
  output logic [`EXU_ADDR_SIZE-1:0]  o_agu_cmd_addr,
  output itag_t                      o_agu_cmd_itag,
  input  logic                       i_lsu_valid,   // LSU write-back
  output logic                       o_lsu_ready,
  input  word_t                      i_lsu_wdat,
  input  itag_t                      i_lsu_itag,
  output logic                       o_wbck_ena,    // Retire trace
  output rfidx_t                     o_wbck_rdidx,
  output word_t                      o_wbck_wdat,
  output logic                       o_oitf_empty,
  output logic                       o_exu_active
);

  rfidx_t  dec_rs1idx, dec_rs2idx, dec_rdidx;
  logic    dec_rs2en, dec_rdwen, dec_use_imm, dec_load;
  word_t   dec_imm;
  alu_op_e dec_alu_op;
  word_t   rf_rs1, rf_rs2;
  word_t   alu_result;
  logic    disp_alu_valid, alu_wbck_ready, disp_oitf_ena;
  logic    oitf_full, oitf_ret_ena;
  logic    match_rs1, match_rs2, match_rd;
  itag_t   oitf_ret_ptr;
  rfidx_t  oitf_ret_rdidx;

  ////////////////////////////////////////////////////////////
  exu_regfile u_regfile (
    .clk (clk), .i_rst_n (i_rst_n),
    .i_rs1idx (dec_rs1idx), .i_rs2idx (dec_rs2idx),
    .i_wen (o_wbck_ena), .i_wrdidx (o_wbck_rdidx), .i_wdat (o_wbck_wdat),
    .o_rs1_dat (rf_rs1), .o_rs2_dat (rf_rs2)
  );

  exu_decode u_decode (
    .i_instr (i_ir),
    .o_rs1idx (dec_rs1idx), .o_rs2idx (dec_rs2idx), .o_rdidx (dec_rdidx),
    .o_rs2en (dec_rs2en), .o_rdwen (dec_rdwen), .o_imm (dec_imm),
    .o_alu_op (dec_alu_op), .o_use_imm (dec_use_imm), .o_load (dec_load)
  );

  exu_disp u_disp (
    .i_valid (i_valid), .i_rs2en (dec_rs2en), .i_rdwen (dec_rdwen), .i_load (dec_load),
    .i_oitf_full (oitf_full),
    .i_match_rs1 (match_rs1), .i_match_rs2 (match_rs2), .i_match_rd (match_rd),
    .i_agu_cmd_ready (i_agu_cmd_ready), .i_alu_wbck_ready (alu_wbck_ready),
    .o_ready (o_ready), .o_alu_valid (disp_alu_valid),
    .o_agu_cmd_valid (o_agu_cmd_valid), .o_oitf_ena (disp_oitf_ena)
  );

  exu_oitf u_oitf (
    .clk (clk), .i_rst_n (i_rst_n),
    .i_dis_ena (disp_oitf_ena), .i_dis_rdidx (dec_rdidx), .i_ret_ena (oitf_ret_ena),
    .i_rs1idx (dec_rs1idx), .i_rs2idx (dec_rs2idx), .i_rdidx (dec_rdidx),
    .o_dis_ptr (o_agu_cmd_itag), .o_ret_ptr (oitf_ret_ptr), .o_ret_rdidx (oitf_ret_rdidx),
    .o_full (oitf_full), .o_empty (o_oitf_empty),
    .o_match_rs1 (match_rs1), .o_match_rs2 (match_rs2), .o_match_rd (match_rd)
  );

  exu_alu u_alu (
    .i_op (dec_alu_op), .i_rs1 (rf_rs1), .i_rs2 (rf_rs2),
    .i_imm (dec_imm), .i_use_imm (dec_use_imm),
    .o_result (alu_result), .o_addr (o_agu_cmd_addr)
  );

  exu_wbck u_wbck (
    .clk (clk), .i_rst_n (i_rst_n),
    .i_alu_valid (disp_alu_valid), .i_alu_rdidx (dec_rdidx), .i_alu_wdat (alu_result),
    .i_lsu_valid (i_lsu_valid), .i_lsu_wdat (i_lsu_wdat), .i_lsu_itag (i_lsu_itag),
    .i_oitf_ret_ptr (oitf_ret_ptr), .i_oitf_ret_rdidx (oitf_ret_rdidx),
    .o_alu_ready (alu_wbck_ready), .o_lsu_ready (o_lsu_ready), .o_oitf_ret_ena (oitf_ret_ena),
    .o_rf_wen (o_wbck_ena), .o_rf_rdidx (o_wbck_rdidx), .o_rf_wdat (o_wbck_wdat)
  );

  assign o_exu_active = ~o_oitf_empty | i_valid; // Loads in flight or work pending

endmodule

/* rtl/exu_wbck.sv */
// Write-back: LSU accept, OITF retire, register port arbitration
`timescale 1ns/10ps
`include "exu_settings.svh"

module exu_wbck import exu_pipe_pkg::*; (
  input  logic   clk,
  input  logic   i_rst_n,
  input  logic   i_alu_valid,
  input  rfidx_t i_alu_rdidx,
  input  word_t  i_alu_wdat,
  input  logic   i_lsu_valid,
  input  word_t  i_lsu_wdat,
  input  itag_t  i_lsu_itag,
  input  itag_t  i_oitf_ret_ptr,
  input  rfidx_t i_oitf_ret_rdidx,
  output logic   o_alu_ready,
  output logic   o_lsu_ready,
  output logic   o_oitf_ret_ena,
  output logic   o_rf_wen,
  output rfidx_t o_rf_rdidx,
  output word_t  o_rf_wdat
);

  logic lsu_ready_q;
  logic lsu_fire;

  // Ready rises once out of reset and stays up
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      lsu_ready_q <= 1'b0;
    end else begin
      lsu_ready_q <= 1'b1;
    end
  end

  assign o_lsu_ready = lsu_ready_q;

  // Only the oldest outstanding load may retire
  assign lsu_fire       = i_lsu_valid & lsu_ready_q & (i_lsu_itag == i_oitf_ret_ptr);
  assign o_oitf_ret_ena = lsu_fire;

  ////////////////////////////////////////////////////////////
  // Long pipe owns the port whenever the LSU presents data
  assign o_alu_ready = ~i_lsu_valid;

  assign o_rf_wen   = (lsu_fire & (i_oitf_ret_rdidx != '0)) | (i_alu_valid & o_alu_ready);
  assign o_rf_rdidx = lsu_fire ? i_oitf_ret_rdidx : i_alu_rdidx;
  assign o_rf_wdat  = lsu_fire ? i_lsu_wdat : i_alu_wdat;

endmodule

/* rtl/exu_alu.sv */
// Single-cycle ALU with the load address adder
`timescale 1ns/10ps
`include "exu_settings.svh"

module exu_alu import exu_isa_pkg::*; import exu_pipe_pkg::*; (
  input  alu_op_e i_op,
  input  word_t   i_rs1,
  input  word_t   i_rs2,
  input  word_t   i_imm,
  input  logic    i_use_imm,
  output word_t   o_result,
  output logic [`EXU_ADDR_SIZE-1:0] o_addr
);

  word_t op2;
  logic  lt;

  assign op2 = i_use_imm ? i_imm : i_rs2;
  assign lt  = $signed(i_rs1) < $signed(op2); // Signed compare for SLT

  always_comb begin
    case (i_op)
      ALU_ADD: o_result = i_rs1 + op2;
      ALU_SUB: o_result = i_rs1 - op2;
      ALU_AND: o_result = i_rs1 & op2;
      ALU_OR:  o_result = i_rs1 | op2;
      ALU_XOR: o_result = i_rs1 ^ op2;
      ALU_SLT: o_result = {{(`EXU_XLEN-1){1'b0}}, lt};
      default: o_result = '0;
    endcase
  end

  // AGU address, always rs1 plus immediate
  assign o_addr = `EXU_ADDR_SIZE'(i_rs1 + i_imm);

endmodule

/* disp/exu_oitf.sv */
// Outstanding-load table: circular buffer of rd indices with hazard match flags
`timescale 1ns/10ps
`include "exu_settings.svh"

module exu_oitf import exu_pipe_pkg::*; (
  input  logic   clk,
  input  logic   i_rst_n,
  input  logic   i_dis_ena,
  input  rfidx_t i_dis_rdidx,
  input  logic   i_ret_ena,
  input  rfidx_t i_rs1idx,
  input  rfidx_t i_rs2idx,
  input  rfidx_t i_rdidx,
  output itag_t  o_dis_ptr,
  output itag_t  o_ret_ptr,
  output rfidx_t o_ret_rdidx,
  output logic   o_full,
  output logic   o_empty,
  output logic   o_match_rs1,
  output logic   o_match_rs2,
  output logic   o_match_rd
);

  localparam int DEPTH = `EXU_OITF_DEPTH;
  localparam int PW    = `EXU_ITAG_WIDTH;

  logic [PW:0]      wr_q;  // {wrap, pointer}
  logic [PW:0]      rt_q;
  logic [DEPTH-1:0] vld_q;
  rfidx_t           rd_q [DEPTH];

  // Advance a pointer, flipping the wrap bit at the last entry
  function automatic logic [PW:0] ptr_inc(input logic [PW:0] cur);
    logic [PW:0] nxt;
    if (cur[PW-1:0] == itag_t'(DEPTH - 1)) begin
      nxt = {~cur[PW], {PW{1'b0}}};
    end else begin
      nxt = cur + {{PW{1'b0}}, 1'b1};
    end
    return nxt;
  endfunction

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_q  <= '0;
      rt_q  <= '0;
      vld_q <= '0;
    end else begin
      if (i_dis_ena) wr_q <= ptr_inc(wr_q);
      if (i_ret_ena) rt_q <= ptr_inc(rt_q);
      for (int i = 0; i < DEPTH; i++) begin
        if (i_dis_ena && (wr_q[PW-1:0] == itag_t'(i))) begin
          vld_q[i] <= 1'b1;
        end else if (i_ret_ena && (rt_q[PW-1:0] == itag_t'(i))) begin
          vld_q[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_dis_ena) rd_q[wr_q[PW-1:0]] <= i_dis_rdidx; // Destination of the new load
  end

  assign o_dis_ptr   = wr_q[PW-1:0];
  assign o_ret_ptr   = rt_q[PW-1:0];
  assign o_ret_rdidx = rd_q[rt_q[PW-1:0]];
  assign o_full      = (wr_q[PW-1:0] == rt_q[PW-1:0]) & (wr_q[PW] != rt_q[PW]);
  assign o_empty     = (wr_q == rt_q);

  ////////////////////////////////////////////////////////////
  // Compare each live entry against the dispatching instruction
  always_comb begin
    o_match_rs1 = 1'b0;
    o_match_rs2 = 1'b0;
    o_match_rd  = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      o_match_rs1 |= vld_q[i] & (rd_q[i] == i_rs1idx);
      o_match_rs2 |= vld_q[i] & (rd_q[i] == i_rs2idx);
      o_match_rd  |= vld_q[i] & (rd_q[i] == i_rdidx);
    end
  end

endmodule

/* disp/exu_disp.sv */
// Dispatch: hazard stall, ALU or load routing, ready and enable strobes
`timescale 1ns/10ps
`include "exu_settings.svh"

module exu_disp (
  input  logic i_valid,
  input  logic i_rs2en,
  input  logic i_rdwen,
  input  logic i_load,
  input  logic i_oitf_full,
  input  logic i_match_rs1,
  input  logic i_match_rs2,
  input  logic i_match_rd,
  input  logic i_agu_cmd_ready,
  input  logic i_alu_wbck_ready,
  output logic o_ready,
  output logic o_alu_valid,
  output logic o_agu_cmd_valid,
  output logic o_oitf_ena
);

  logic stall;

  ////////////////////////////////////////////////////////////
  // Dependency on an outstanding load
  assign stall = i_match_rs1 |
                 (i_match_rs2 & i_rs2en) |
                 (i_match_rd & i_rdwen); // WAW against the pending rd

  ////////////////////////////////////////////////////////////
  // Routing
  assign o_alu_valid     = i_valid & ~i_load & i_rdwen & ~stall; // Write request only
  assign o_agu_cmd_valid = i_valid & i_load & ~stall & ~i_oitf_full;

  // Load needs the LSU and a free OITF slot, the rest needs the write port
  assign o_ready = ~stall & (i_load ? (i_agu_cmd_ready & ~i_oitf_full)
                                    : i_alu_wbck_ready);

  // Allocate on the AGU handshake
  assign o_oitf_ena = o_agu_cmd_valid & i_agu_cmd_ready;

endmodule

/* rtl/exu_decode.sv */
// Instruction decoder: register fields, immediate, ALU operation, class
`timescale 1ns/10ps
`include "exu_settings.svh"

module exu_decode import exu_isa_pkg::*; import exu_pipe_pkg::*; (
  input  logic [`EXU_INSTR_SIZE-1:0] i_instr,
  output rfidx_t  o_rs1idx,
  output rfidx_t  o_rs2idx,
  output rfidx_t  o_rdidx,
  output logic    o_rs2en,
  output logic    o_rdwen,
  output word_t   o_imm,
  output alu_op_e o_alu_op,
  output logic    o_use_imm,
  output logic    o_load
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  alu_op_e    f3_op;
  logic       f3_known;
  logic       is_op;
  logic       is_opimm;
  logic       is_lw;

  assign opcode = opcode_e'(i_instr[6:0]);
  assign funct3 = i_instr[14:12];
  assign funct7 = i_instr[31:25];

  assign o_rdidx  = i_instr[11:7];
  assign o_rs1idx = i_instr[19:15];
  assign o_rs2idx = i_instr[24:20];
  assign o_imm    = {{(`EXU_XLEN-12){i_instr[31]}}, i_instr[31:20]}; // I-type, sign-extended

  // funct3 to operation, shared by register and immediate forms
  always_comb begin
    f3_known = 1'b1;
    case (funct3)
      F3_ADD_SUB: f3_op = ALU_ADD;
      F3_SLT:     f3_op = ALU_SLT;
      F3_XOR:     f3_op = ALU_XOR;
      F3_OR:      f3_op = ALU_OR;
      F3_AND:     f3_op = ALU_AND;
      default: begin
        f3_op    = ALU_ADD;
        f3_known = 1'b0; // Shifts and SLTU not handled
      end
    endcase
  end

  assign is_op    = (opcode == OPC_OP) && f3_known &&
                    ((funct7 == F7_BASE) || ((funct7 == F7_SUB) && (funct3 == F3_ADD_SUB)));
  assign is_opimm = (opcode == OPC_OP_IMM) && f3_known && (funct3 != F3_SLT); // No SLTI
  assign is_lw    = (opcode == OPC_LOAD) && (funct3 == F3_LW);

  assign o_alu_op  = (is_op && (funct7 == F7_SUB)) ? ALU_SUB : (is_lw ? ALU_ADD : f3_op);
  assign o_use_imm = (opcode != OPC_OP);
  assign o_rs2en   = is_op;
  assign o_load    = is_lw;
  // Unsupported encodings and rd of x0 retire silently
  assign o_rdwen   = (is_op || is_opimm || is_lw) && (o_rdidx != '0);

endmodule

/* rtl/exu_regfile.sv */
// Integer register file, two read ports and one write port, x0 tied to zero
`timescale 1ns/10ps
`include "exu_settings.svh"

module exu_regfile import exu_pipe_pkg::*; (
  input  logic   clk,
  input  logic   i_rst_n,
  input  rfidx_t i_rs1idx,
  input  rfidx_t i_rs2idx,
  input  logic   i_wen,
  input  rfidx_t i_wrdidx,
  input  word_t  i_wdat,
  output word_t  o_rs1_dat,
  output word_t  o_rs2_dat
);

  word_t rf_q [`EXU_RF_NUM];

  assign rf_q[0] = '0; // x0 reads as zero, never written

  for (genvar i = 1; i < `EXU_RF_NUM; i++) begin : g_rf
    always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        rf_q[i] <= '0;
      end else if (i_wen && (i_wrdidx == rfidx_t'(i))) begin
        rf_q[i] <= i_wdat;
      end
    end
  end

  // Combinational reads
  assign o_rs1_dat = rf_q[i_rs1idx];
  assign o_rs2_dat = rf_q[i_rs2idx];

endmodule

/* common/exu_pipe_pkg.sv */
// Pipeline types: data word, register index, instruction tag
`include "exu_settings.svh"

package exu_pipe_pkg;

  // One register-file word
  typedef logic [`EXU_XLEN-1:0] word_t;

  // Register index
  typedef logic [`EXU_RFIDX_WIDTH-1:0] rfidx_t;

  // OITF entry pointer, travels with a load as its tag
  typedef logic [`EXU_ITAG_WIDTH-1:0] itag_t;

endpackage

/* common/exu_isa_pkg.sv */
// Opcode and ALU operation enums, funct3 and funct7 encodings
package exu_isa_pkg;

  // Major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5
  } alu_op_e;

  // funct3 field
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_LW      = 3'b010; // Word load

  // funct7 field
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

endpackage

/* common/exu_settings.svh */
// Width and depth macros for the execution stage
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// Datapath
`define EXU_XLEN        32
`define EXU_INSTR_SIZE  32
`define EXU_ADDR_SIZE   32

// Register file
`define EXU_RFIDX_WIDTH 5
`define EXU_RF_NUM      32

// Outstanding long-pipe table, tag is log2 of depth
`define EXU_OITF_DEPTH  2
`define EXU_ITAG_WIDTH  1

`endif
